// File: include/timer_settings.svh
`ifndef TIMER_SETTINGS_SVH
`define TIMER_SETTINGS_SVH

// time pulses in one memory cycle, T01 through T12
`define TIME_PULSES 12

// clock cycles spent in each time pulse
// read, write, clear and set phases
`define PHASES_PER_PULSE 4

// stages in the Johnson ring, P01 through P05
// gives a ten state cycle
`define RING_STAGES 5

`endif

// File: src/timer_pkg.sv
`default_nettype none

`include "timer_settings.svh"

package timer_pkg;

    // one-hot time pulse, bit 0 is T01 and the top bit is T12
    typedef logic [`TIME_PULSES-1:0] time_pulse_t;

    // ring stages, bit 0 is P01
    typedef logic [`RING_STAGES-1:0] ring_state_t;

    // one state per clock inside a time pulse
    typedef enum logic [$clog2(`PHASES_PER_PULSE)-1:0] {
        PH_READ,
        PH_WRITE,
        PH_CLEAR,
        PH_SET
    } phase_t;

    // read, write and clear timing strobes
    typedef struct packed {
        logic rt;
        logic wt;
        logic ct;
    } phase_strobes_t;

    // strobes decoded from the ring
    typedef struct packed {
        logic sb0;
        logic sb1;
        logic sb2;
        logic sb4;
        logic edset;
    } ring_strobes_t;

    // restart sources, goj1 only holds the go state
    typedef struct packed {
        logic standby;
        logic alarm;
        logic manual_start;
        logic start1;
        logic start2;
        logic goj1;
    } restart_req_t;

endpackage

`default_nettype wire

// File: src/phase_gen.sv
`default_nettype none

module phase_gen
    import timer_pkg::*;
(
    input  logic           clock,
    input  logic           reset,
    input  logic           stop,
    output phase_strobes_t phase_strobes,
    output logic           odd_set,
    output logic           even_set,
    output logic           ring_step,
    output logic           ovf,
    output logic           unf,
    input  logic           wl15,
    input  logic           wl16
);

    phase_t phase;
    phase_t phase_next;
    // high when the next set pulse is an odd set
    logic   odd_turn;
    logic   set_coming;

    // read, write, clear, set and around again
    always_comb begin
        case (phase)
            PH_READ:  phase_next = PH_WRITE;
            PH_WRITE: phase_next = PH_CLEAR;
            PH_CLEAR: phase_next = PH_SET;
            default:  phase_next = PH_READ;
        endcase
    end

    assign set_coming = (phase_next == PH_SET);

    // strobes are decoded from the next phase so they line up with it
    always_ff @(posedge clock) begin
        if (reset) begin
            // parked in set, so read is the first phase after release
            phase         <= PH_SET;
            phase_strobes <= '0;
            ring_step     <= 1'b0;
            odd_set       <= 1'b0;
            even_set      <= 1'b0;
            odd_turn      <= 1'b1;
        end else begin
            phase            <= phase_next;
            phase_strobes.rt <= (phase_next == PH_READ);
            phase_strobes.wt <= (phase_next == PH_WRITE);
            phase_strobes.ct <= (phase_next == PH_CLEAR);
            ring_step        <= set_coming;
            // stop blocks odd set only, time pulses then hang at T12
            odd_set          <= set_coming && odd_turn && !stop;
            even_set         <= set_coming && !odd_turn;
            // parity keeps alternating even while stopped
            if (set_coming) begin
                odd_turn <= ~odd_turn;
            end
        end
    end

    // overflow strobe is ct itself
    // sign bits 01 means overflow, 10 means underflow
    assign ovf = phase_strobes.ct & wl15 & ~wl16;
    assign unf = phase_strobes.ct & ~wl15 & wl16;

endmodule

`default_nettype wire

// File: src/time_pulse_gen.sv
`default_nettype none

`include "timer_settings.svh"

module time_pulse_gen
    import timer_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        odd_set,
    input  logic        even_set,
    input  logic        gojam,
    output time_pulse_t time_pulse
);

    // T01, T03 .. T11 sit on the even bit positions
    localparam time_pulse_t ODD_PULSES  = {(`TIME_PULSES/2){2'b01}};
    // T02, T04 .. T12 sit on the odd bit positions
    localparam time_pulse_t EVEN_PULSES = {(`TIME_PULSES/2){2'b10}};
    // T12 alone
    localparam time_pulse_t PULSE_T12   = {1'b1, {(`TIME_PULSES-1){1'b0}}};

    logic        on_odd_pulse;
    logic        on_even_pulse;
    logic        advance;
    time_pulse_t pulse_next;

    assign on_odd_pulse  = |(time_pulse & ODD_PULSES);
    assign on_even_pulse = |(time_pulse & EVEN_PULSES);

    // odd set leaves an even pulse, even set leaves an odd pulse
    // a missing odd set therefore freezes the sequence on T12
    assign advance = (odd_set & on_even_pulse) | (even_set & on_odd_pulse);

    // rotate up by one, T12 wraps to T01
    assign pulse_next = {time_pulse[`TIME_PULSES-2:0], time_pulse[`TIME_PULSES-1]};

    always_ff @(posedge clock) begin
        if (reset || gojam) begin
            // restart parks the sequence on T12 until gojam drops
            time_pulse <= PULSE_T12;
        end else if (advance) begin
            time_pulse <= pulse_next;
        end
    end

endmodule

`default_nettype wire

// File: src/ring_counter.sv
`default_nettype none

module ring_counter
    import timer_pkg::*;
(
    input  logic          clock,
    input  logic          reset,
    input  logic          ring_step,
    output ring_state_t   ring,
    output ring_strobes_t ring_strobes
);

    // stage positions inside the ring vector
    localparam int P01 = 0;
    localparam int P02 = 1;
    localparam int P03 = 2;
    localparam int P04 = 3;
    localparam int P05 = 4;

    ring_state_t ring_next;

    always_comb begin
        ring_next = ring;
        if (ring_step) begin
            // Johnson shift, P01 picks up the inverted last stage
            ring_next = {ring[P04:P01], ~ring[P05]};
        end
        // edset only decodes on illegal patterns
        // holding P03 set walks those back into the legal cycle
        if (ring_strobes.edset) begin
            ring_next[P03] = 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            ring <= '0;
        end else begin
            ring <= ring_next;
        end
    end

    // strobe decode of the registered ring
    assign ring_strobes.sb0   = ring[P02] & ~ring[P05];
    assign ring_strobes.sb1   = ring[P03] & ring[P05];
    assign ring_strobes.sb2   = ring[P05] & ~ring[P02];
    assign ring_strobes.sb4   = ring[P02] & ~ring[P04];
    assign ring_strobes.edset = ring[P03] & ~ring[P02] & ~ring[P04];

endmodule

`default_nettype wire

// File: src/restart_control.sv
`default_nettype none

`include "timer_settings.svh"

module restart_control
    import timer_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  logic         even_set,
    input  logic         manual_stop,
    input  restart_req_t restart_req,
    input  time_pulse_t  time_pulse,
    output logic         gojam,
    output logic         stop
);

    logic any_req;
    // held half of the go-set latch
    logic go_hold;
    logic go_set;
    logic restart_stop;
    logic manual_stop_latch;
    logic t12;

    // every restart source except goj1
    assign any_req = restart_req.standby | restart_req.alarm | restart_req.manual_start
                   | restart_req.start1 | restart_req.start2;

    // go-set follows a request at once and stays up while goj1 is low
    assign go_set = any_req | go_hold;

    assign t12 = time_pulse[`TIME_PULSES-1];

    always_ff @(posedge clock) begin
        if (reset) begin
            go_hold <= 1'b0;
        end else if (any_req) begin
            go_hold <= 1'b1;
        end else if (restart_req.goj1) begin
            go_hold <= 1'b0;
        end
    end

    // restart-stop and manual-stop both change only on even set
    always_ff @(posedge clock) begin
        if (reset) begin
            restart_stop      <= 1'b0;
            manual_stop_latch <= 1'b0;
        end else if (even_set) begin
            // restart stop sets on any even set, releases only at T12
            if (go_set) begin
                restart_stop <= 1'b1;
            end else if (t12) begin
                restart_stop <= 1'b0;
            end
            // manual stop enters at T12, leaves at any even set
            if (manual_stop && t12) begin
                manual_stop_latch <= 1'b1;
            end else if (!manual_stop) begin
                manual_stop_latch <= 1'b0;
            end
        end
    end

    // start2 jams straight through without waiting for even set
    assign gojam = restart_stop | restart_req.start2;
    assign stop  = restart_stop | manual_stop_latch;

endmodule

`default_nettype wire

// File: src/timer_top.sv
`default_nettype none

module timer_top
    import timer_pkg::*;
(
    input  logic           clock,
    input  logic           reset,
    input  restart_req_t   restart_req,
    input  logic           manual_stop,
    input  logic           wl15,
    input  logic           wl16,
    output phase_strobes_t phase_strobes,
    output time_pulse_t    time_pulse,
    output ring_state_t    ring,
    output ring_strobes_t  ring_strobes,
    output logic           gojam,
    output logic           stop,
    output logic           ovf,
    output logic           unf
);

    // set pulses from the phase counter
    logic odd_set;
    logic even_set;
    // once per time pulse, in the set phase
    logic ring_step;

    // phase counter, strobes and overflow decode
    phase_gen u_phase_gen (
        .clock         (clock),
        .reset         (reset),
        .stop          (stop),
        .phase_strobes (phase_strobes),
        .odd_set       (odd_set),
        .even_set      (even_set),
        .ring_step     (ring_step),
        .ovf           (ovf),
        .unf           (unf),
        .wl15          (wl15),
        .wl16          (wl16)
    );

    // T01 to T12
    time_pulse_gen u_time_pulse_gen (
        .clock      (clock),
        .reset      (reset),
        .odd_set    (odd_set),
        .even_set   (even_set),
        .gojam      (gojam),
        .time_pulse (time_pulse)
    );

    // keeps stepping through a stop, only the time pulses freeze
    ring_counter u_ring_counter (
        .clock        (clock),
        .reset        (reset),
        .ring_step    (ring_step),
        .ring         (ring),
        .ring_strobes (ring_strobes)
    );

    // gojam and stop, T12 comes back from the pulse generator
    restart_control u_restart_control (
        .clock       (clock),
        .reset       (reset),
        .even_set    (even_set),
        .manual_stop (manual_stop),
        .restart_req (restart_req),
        .time_pulse  (time_pulse),
        .gojam       (gojam),
        .stop        (stop)
    );

endmodule

`default_nettype wire

// File: tests/timer_checks.sv
`default_nettype none

`include "timer_settings.svh"

module timer_checks
    import timer_pkg::*;
(
    input  logic           clock,
    input  logic           reset,
    input  restart_req_t   restart_req,
    input  logic           manual_stop,
    input  logic           wl15,
    input  logic           wl16,
    input  phase_strobes_t phase_strobes,
    input  time_pulse_t    time_pulse,
    input  ring_state_t    ring,
    input  ring_strobes_t  ring_strobes,
    input  logic           gojam,
    input  logic           stop,
    input  logic           ovf,
    input  logic           unf,
    input  logic [127:0]   test_name,
    output logic           check_failed
);

    // goes high at the first reset edge, model state is known from then on
    logic           checking = 1'b0;
    logic           failed = 1'b0;
    // model of the phase counter
    logic           started;
    logic [1:0]     step;
    logic           odd_next;
    logic           odd_set;
    logic           even_set;
    // model time pulse as a number 1 to 12
    int             pulse;
    // position in the ten state Johnson cycle
    int             ring_pos;
    // model latches
    logic           go_hold;
    logic           restart_stop;
    logic           manual_stop_held;
    // any restart source other than goj1
    logic           any_req;
    logic           go_set;
    phase_strobes_t exp_strobes;
    time_pulse_t    exp_pulse;
    ring_state_t    exp_ring;
    ring_strobes_t  exp_ring_strobes;
    logic           exp_gojam;
    logic           exp_stop;
    logic           exp_ovf;
    logic           exp_unf;

    // legal ring pattern for a cycle position
    // fill from P01 upward, then empty from P01 upward
    function automatic ring_state_t johnson_pattern(input int pos);
        ring_state_t ones;
        ones = '1;
        if (pos <= `RING_STAGES) begin
            return ring_state_t'((1 << pos) - 1);
        end
        return ones & ~ring_state_t'((1 << (pos - `RING_STAGES)) - 1);
    endfunction

    task automatic report_mismatch(input string what, input logic [15:0] expected,
                                   input logic [15:0] actual);
        $display("mismatch in test %0s: %0s expected %h actual %h",
                 test_name, what, expected, actual);
        failed = 1'b1;
    endtask

    task automatic report_problem(input string what);
        $display("test %0s: %0s", test_name, what);
        failed = 1'b1;
    endtask

    assign check_failed = failed;

    assign any_req = restart_req.standby | restart_req.alarm | restart_req.manual_start
                   | restart_req.start1 | restart_req.start2;
    assign go_set  = any_req | go_hold;

    assign exp_gojam = restart_stop | restart_req.start2;
    assign exp_stop  = restart_stop | manual_stop_held;

    // step 0 is read, 1 write, 2 clear, 3 set
    assign exp_strobes.rt = started && step == 2'd0;
    assign exp_strobes.wt = started && step == 2'd1;
    assign exp_strobes.ct = started && step == 2'd2;
    assign exp_ovf        = exp_strobes.ct && wl15 && !wl16;
    assign exp_unf        = exp_strobes.ct && !wl15 && wl16;

    assign exp_pulse = time_pulse_t'(1) << (pulse - 1);
    assign exp_ring  = johnson_pattern(ring_pos);

    assign exp_ring_strobes.sb0   = exp_ring[1] & ~exp_ring[4];
    assign exp_ring_strobes.sb1   = exp_ring[2] & exp_ring[4];
    assign exp_ring_strobes.sb2   = exp_ring[4] & ~exp_ring[1];
    assign exp_ring_strobes.sb4   = exp_ring[1] & ~exp_ring[3];
    assign exp_ring_strobes.edset = exp_ring[2] & ~exp_ring[1] & ~exp_ring[3];

    always @(posedge clock) begin
        if (reset) begin
            checking         <= 1'b1;
            started          <= 1'b0;
            step             <= 2'd3;
            odd_next         <= 1'b1;
            odd_set          <= 1'b0;
            even_set         <= 1'b0;
            pulse            <= `TIME_PULSES;
            ring_pos         <= 0;
            go_hold          <= 1'b0;
            restart_stop     <= 1'b0;
            manual_stop_held <= 1'b0;
        end else begin
            started  <= 1'b1;
            step     <= step + 2'd1;
            odd_set  <= 1'b0;
            even_set <= 1'b0;
            // set pulse lands in the set step, odd and even take turns
            if (step == 2'd2) begin
                odd_set  <= odd_next && !exp_stop;
                even_set <= !odd_next;
                odd_next <= !odd_next;
            end
            if (started && step == 2'd3) begin
                ring_pos <= (ring_pos + 1) % (2 * `RING_STAGES);
            end
            if (exp_gojam) begin
                pulse <= `TIME_PULSES;
            end else if (odd_set && pulse % 2 == 0) begin
                pulse <= pulse % `TIME_PULSES + 1;
            end else if (even_set && pulse % 2 == 1) begin
                pulse <= pulse + 1;
            end
            // a request sets the hold, goj1 with no request clears it
            if (any_req) begin
                go_hold <= 1'b1;
            end else if (restart_req.goj1) begin
                go_hold <= 1'b0;
            end
            if (even_set) begin
                if (go_set) begin
                    restart_stop <= 1'b1;
                end else if (pulse == `TIME_PULSES) begin
                    restart_stop <= 1'b0;
                end
                if (manual_stop && pulse == `TIME_PULSES) begin
                    manual_stop_held <= 1'b1;
                end else if (!manual_stop) begin
                    manual_stop_held <= 1'b0;
                end
            end
        end
    end

    // outputs are compared at the rising edge, before any register moves
    always @(posedge clock) begin
        if (checking) begin
            assert (phase_strobes == exp_strobes)
                else report_mismatch("phase strobes", 16'(exp_strobes), 16'(phase_strobes));
            assert ($onehot0({phase_strobes.rt, phase_strobes.wt, phase_strobes.ct}))
                else report_problem("rt, wt and ct are high in the same cycle");
            assert (ovf == exp_ovf)
                else report_mismatch("ovf", 16'(exp_ovf), 16'(ovf));
            assert (unf == exp_unf)
                else report_mismatch("unf", 16'(exp_unf), 16'(unf));
            assert ($onehot(time_pulse))
                else report_problem("time pulse is not one-hot");
            assert (time_pulse == exp_pulse)
                else report_mismatch("time pulse", 16'(exp_pulse), 16'(time_pulse));
            assert (ring == exp_ring)
                else report_mismatch("ring", 16'(exp_ring), 16'(ring));
            assert (ring_strobes == exp_ring_strobes)
                else report_mismatch("ring strobes", 16'(exp_ring_strobes),
                                     16'(ring_strobes));
            assert (gojam == exp_gojam)
                else report_mismatch("gojam", 16'(exp_gojam), 16'(gojam));
            assert (stop == exp_stop)
                else report_mismatch("stop", 16'(exp_stop), 16'(stop));
        end
    end

endmodule

`default_nettype wire

// File: tests/timer_tb.sv
`default_nettype none

`include "timer_settings.svh"

module timer_tb
    import timer_pkg::*;
();

    localparam int CLOCK_PERIOD   = 40;
    localparam int RESET_CYCLES   = 16;
    // one memory cycle, T01 through T12
    localparam int MEMORY_CYCLE   = `TIME_PULSES * `PHASES_PER_PULSE;
    localparam int RUN_CYCLES     = 3 * MEMORY_CYCLE;
    localparam int RESTART_RUNS   = 7;
    // gap, wait for gojam, hold, release at T12 and T01
    localparam int RESTART_CYCLES = RESTART_RUNS * (8 + 16 + 2 * MEMORY_CYCLE);
    localparam int STOP_CYCLES    = 3 * MEMORY_CYCLE + 64;
    localparam int TAIL_CYCLES    = MEMORY_CYCLE;
    localparam int TEST_CYCLES    = RESET_CYCLES + RUN_CYCLES + RESTART_CYCLES
                                  + STOP_CYCLES + TAIL_CYCLES;

    logic           clock;
    logic           reset;
    restart_req_t   restart_req;
    logic           manual_stop;
    logic           wl15;
    logic           wl16;
    phase_strobes_t phase_strobes;
    time_pulse_t    time_pulse;
    ring_state_t    ring;
    ring_strobes_t  ring_strobes;
    logic           gojam;
    logic           stop;
    logic           ovf;
    logic           unf;
    logic [127:0]   test_name;
    logic           check_failed;
    logic [15:0]    lfsr_state = 16'd50;

    timer_top DUT (
        .clock         (clock),
        .reset         (reset),
        .restart_req   (restart_req),
        .manual_stop   (manual_stop),
        .wl15          (wl15),
        .wl16          (wl16),
        .phase_strobes (phase_strobes),
        .time_pulse    (time_pulse),
        .ring          (ring),
        .ring_strobes  (ring_strobes),
        .gojam         (gojam),
        .stop          (stop),
        .ovf           (ovf),
        .unf           (unf)
    );

    // reference model and output checks
    timer_checks u_checks (
        .clock         (clock),
        .reset         (reset),
        .restart_req   (restart_req),
        .manual_stop   (manual_stop),
        .wl15          (wl15),
        .wl16          (wl16),
        .phase_strobes (phase_strobes),
        .time_pulse    (time_pulse),
        .ring          (ring),
        .ring_strobes  (ring_strobes),
        .gojam         (gojam),
        .stop          (stop),
        .ovf           (ovf),
        .unf           (unf),
        .test_name     (test_name),
        .check_failed  (check_failed)
    );

    // 16 bit Fibonacci LFSR, taps 16 15 13 4
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[14] ^ state[12] ^ state[3];
        return {state[14:0], feedback};
    endfunction

    // one LFSR step per bit
    function automatic int unsigned random_bits(input int count);
        int unsigned value;
        value = 0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = (value << 1) | 32'(lfsr_state[0]);
        end
        return value;
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%0s", reason);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    // falling edge, then fresh write-bus sign bits
    task automatic next_cycle();
        int unsigned bits;
        @(negedge clock);
        bits = random_bits(2);
        wl15 = bits[0];
        wl16 = bits[1];
    endtask

    task automatic idle_cycles(input int count);
        repeat (count) begin
            next_cycle();
        end
    endtask

    task automatic wait_gojam(input logic level);
        do begin
            next_cycle();
        end while (gojam !== level);
    endtask

    task automatic wait_stop(input logic level);
        do begin
            next_cycle();
        end while (stop !== level);
    endtask

    // T01 marks the sequence running again
    task automatic wait_first_pulse();
        do begin
            next_cycle();
        end while (time_pulse[0] !== 1'b1);
    endtask

    task automatic apply_restart(input int kind);
        int hold;
        idle_cycles(int'(random_bits(3)));
        restart_req = '0;
        case (kind)
            0: restart_req.standby = 1'b1;
            1: restart_req.alarm = 1'b1;
            2: restart_req.manual_start = 1'b1;
            3: restart_req.start1 = 1'b1;
            default: restart_req.start2 = 1'b1;
        endcase
        // gojam comes at the next even set, or at once for start2
        wait_gojam(1'b1);
        hold = int'(random_bits(4));
        idle_cycles(hold);
        restart_req = '0;
        restart_req.goj1 = 1'b1;
        wait_gojam(1'b0);
        wait_first_pulse();
        restart_req.goj1 = 1'b0;
    endtask

    task automatic apply_manual_stop();
        int hold;
        idle_cycles(int'(random_bits(3)));
        manual_stop = 1'b1;
        // an even set only meets T12 while the sequence is parked there
        // a standby restart parks it, the stop latch then enters at T12
        restart_req = '0;
        restart_req.standby = 1'b1;
        wait_gojam(1'b1);
        restart_req = '0;
        restart_req.goj1 = 1'b1;
        // gojam drops, manual stop alone keeps stop up
        wait_gojam(1'b0);
        restart_req.goj1 = 1'b0;
        // pulses hold at T12 here while the ring keeps going
        hold = 24 + int'(random_bits(5));
        idle_cycles(hold);
        manual_stop = 1'b0;
        wait_stop(1'b0);
        wait_first_pulse();
    endtask

    initial begin
        clock = 1'b0;
        forever begin
            #(CLOCK_PERIOD / 2) clock = ~clock;
        end
    end

    always @(posedge check_failed) begin
        stop_with_failure("a check on the DUT outputs failed");
    end

    // watchdog
    initial begin
        #(2 * TEST_CYCLES * CLOCK_PERIOD);
        stop_with_failure("timeout, the tests did not finish in time");
    end

    initial begin
        reset       = 1'b1;
        restart_req = '0;
        manual_stop = 1'b0;
        wl15        = 1'b0;
        wl16        = 1'b0;
        test_name   = "reset";
        idle_cycles(RESET_CYCLES);
        reset = 1'b0;
        // phases, time pulses, ring and overflow with no requests
        test_name = "free_run";
        idle_cycles(RUN_CYCLES);
        // every kind once, then a few picked at random
        test_name = "restart";
        for (int kind = 0; kind < RESTART_RUNS; kind++) begin
            if (kind < 5) begin
                apply_restart(kind);
            end else begin
                apply_restart(int'(random_bits(3) % 5));
            end
        end
        test_name = "manual_stop";
        apply_manual_stop();
        test_name = "tail";
        idle_cycles(TAIL_CYCLES);
        if (check_failed) begin
            stop_with_failure("a check on the DUT outputs failed");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+include
src/timer_pkg.sv
src/phase_gen.sv
src/time_pulse_gen.sv
src/ring_counter.sv
src/restart_control.sv
src/timer_top.sv
tests/timer_checks.sv
tests/timer_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the timer testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module timer_tb -f src.f \
    || { echo "build failed"; exit 1; }
sim_output=$(./obj_dir/Vtimer_tb)
printf '%s\n' "$sim_output"
printf '%s\n' "$sim_output" | grep -qx "Done: no errors" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
